/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := multiCycleControl_tb
RTL_TOP    := multiCycleControl
FILELIST   := all.f
OBJ_DIR    := obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+src
src/mcControlPkg.sv
src/instrDecoder.sv
src/controlSequencer.sv
src/controlSignalDecoder.sv
src/multiCycleControl.sv
bench/multiCycleControl_assertions.sv
bench/multiCycleControl_tb.sv

/* bench/multiCycleControl_assertions.sv */
`default_nettype none

`include "mc_params.svh"

module multiCycleControl_assertions (
	input wire logic Clk,
	input wire logic Reset_signal,
	input wire logic aluZero,
	input wire logic [`MC_STATE_OUT_WIDTH-1:0] stateOut,
	input mcControlPkg::ctrlWord_t ctrl,
	input mcControlPkg::regStrobes_t strobes
);

	import mcControlPkg::*;

	ctrlState_e st;
	logic inWait;
	logic resetLevels;
	logic loadLevels;
	int failCount = 0;	// failed assertions so far

	assign st = ctrlState_e'(stateOut[$bits(ctrlState_e)-1:0]);
	assign inWait = (st == FETCH_WAIT) || (st == LW_WAIT);
	assign resetLevels = ctrl.regReset & strobes.aReset & strobes.bReset & strobes.pcReset
		& strobes.mdrReset & strobes.aluOutReset & strobes.irReset;
	assign loadLevels = ctrl.pcWriteCond | ctrl.pcWrite | ctrl.memWrite | ctrl.irWrite
		| ctrl.regWrite | strobes.aLoad | strobes.bLoad | strobes.pcLoad | strobes.mdrLoad
		| strobes.aluOutLoad;

	resetState: assert property (@(posedge Clk)
		Reset_signal |-> (st == RESET) && resetLevels && !loadLevels)
	else
	begin
		$error("reset strobes or write strobes wrong while Reset_signal is high");
		failCount++;
	end

	// pcLoad in FETCH_WAIT depends on the wait count
	pcLoadRule: assert property (@(posedge Clk) disable iff (Reset_signal)
		(st != FETCH_WAIT) |-> strobes.pcLoad == (((st == BEQ) && aluZero)
		|| ((st == BNE) && !aluZero) || (st == J)))
	else
	begin
		$error("pcLoad does not follow the branch rule in state %0d", st);
		failCount++;
	end

	memStrobes: assert property (@(posedge Clk) disable iff (Reset_signal)
		(ctrl.memWrite == (st == SW)) && (inWait || !strobes.mdrLoad)
		&& (ctrl.regWrite == ((st == R_WAIT) || (st == LUI) || (st == WRITE_BACK))))
	else
	begin
		$error("memWrite, regWrite or mdrLoad active in state %0d", st);
		failCount++;
	end

	// a wait state is left exactly after its mdrLoad cycle
	waitLoad: assert property (@(posedge Clk) disable iff (Reset_signal)
		inWait |=> (st != $past(st)) == $past(strobes.mdrLoad))
	else
	begin
		$error("mdrLoad not in the last cycle of a wait state");
		failCount++;
	end

endmodule

bind multiCycleControl multiCycleControl_assertions strobeChecks (
	.Clk(Clk),
	.Reset_signal(Reset_signal),
	.aluZero(aluZero),
	.stateOut(stateOut),
	.ctrl(ctrl),
	.strobes(strobes)
);

`default_nettype wire

/* bench/multiCycleControl_tb.sv */
`default_nettype none

`include "mc_params.svh"

module multiCycleControl_tb;

	import mcControlPkg::*;

	localparam int memWait = `MC_MEM_WAIT;
	localparam int numInstr = 40;
	localparam int cycleLimit = numInstr * (6 + 2 * memWait) + 100;
	localparam int haltCycles = 20;

	logic Clk;
	logic Reset_signal;
	logic [`MC_OP_WIDTH-1:0] op;
	logic [`MC_OP_WIDTH-1:0] funct;
	logic aluZero;
	logic [`MC_STATE_OUT_WIDTH-1:0] stateOut;
	ctrlWord_t ctrl;
	regStrobes_t strobes;

	logic [31:0] rngState;
	string testName;
	int testErrors;
	int testsRun;
	int testsFailed;
	int assertFails;
	int cycles;
	string classNames [13] = '{"ADD", "SUB", "AND", "XOR", "BEQ", "BNE", "J", "LUI", "LW",
		"SW", "NOP", "undecoded opcode", "BREAK halt"};

	multiCycleControl multiCycleControl_i (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.op(op),
		.funct(funct),
		.aluZero(aluZero),
		.stateOut(stateOut),
		.ctrl(ctrl),
		.strobes(strobes)
	);

	always #5 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: the instruction stream did not finish in %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// MIPS op and funct fields per test class
	function automatic logic [11:0] encode(input int cls);
		case (cls)
			0: return {FUNCT_OP, ADD_FUNCT};
			1: return {FUNCT_OP, SUB_FUNCT};
			2: return {FUNCT_OP, AND_FUNCT};
			3: return {FUNCT_OP, XOR_FUNCT};
			4: return {BEQ_OP, NOP_FUNCT};
			5: return {BNE_OP, NOP_FUNCT};
			6: return {J_OP, NOP_FUNCT};
			7: return {LUI_OP, NOP_FUNCT};
			8: return {LW_OP, NOP_FUNCT};
			9: return {SW_OP, NOP_FUNCT};
			11: return {6'h3f, NOP_FUNCT};	// not decoded, takes the NOP path
			12: return {FUNCT_OP, BREAK_FUNCT};
			default: return {FUNCT_OP, NOP_FUNCT};
		endcase
	endfunction

	// ALU codes ADD 001, SUB 010, AND 011, XOR 110
	function automatic int aluCode(input int cls);
		return (cls == 0) ? 1 : (cls == 1) ? 2 : (cls == 2) ? 3 : 6;
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("[FAIL] %s: %s expected %0d, actual %0d", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic finishTest();
		testsRun++;
		if (testErrors == 0)
			$display("test %0d (%s): ok", testsRun, testName);
		else
		begin
			$display("test %0d (%s): %0d errors", testsRun, testName, testErrors);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	task automatic holdReset(input string name);
		testName = name;
		Reset_signal = 1'b1;
		repeat (8)
		begin
			@(negedge Clk);
			checkValue("stateOut", int'(RESET), int'(stateOut));
			checkValue("all reset strobes", 1, int'(ctrl.regReset & strobes.aReset
				& strobes.bReset & strobes.pcReset & strobes.mdrReset
				& strobes.aluOutReset & strobes.irReset));
		end
		finishTest();
	endtask

	// called on a falling edge one cycle before the expected FETCH
	task automatic runInstr(input int cls, input logic zero);
		ctrlState_e path[$];
		bit last;
		testName = classNames[cls];
		{op, funct} = encode(cls);
		aluZero = zero;
		path.push_back(FETCH);
		for (int i = 0; i < memWait; i++)
			path.push_back(FETCH_WAIT);
		path.push_back(DECODE);
		case (cls)
			0, 1, 2, 3:
			begin
				path.push_back((cls == 0) ? ADD : (cls == 1) ? SUB : (cls == 2) ? AND : XOR);
				path.push_back(R_WAIT);
			end
			4: path.push_back(BEQ);
			5: path.push_back(BNE);
			6: path.push_back(J);
			7: path.push_back(LUI);
			8:
			begin
				path.push_back(LW_ADDR);
				path.push_back(LW);
				for (int i = 0; i < memWait; i++)
					path.push_back(LW_WAIT);
				path.push_back(WRITE_BACK);
			end
			9:
			begin
				path.push_back(SW_ADDR);
				path.push_back(SW);
			end
			12:
			begin
				for (int i = 0; i < haltCycles; i++)
					path.push_back(BREAK);
			end
			default: path.push_back(NOP);
		endcase

		foreach (path[k])
		begin
			@(negedge Clk);
			last = (k + 1 == path.size()) ? 1'b1 : (path[k + 1] != path[k]);
			checkValue("stateOut", int'(path[k]), int'(stateOut));
			case (path[k])
				FETCH_WAIT:
				begin
					checkValue("fetch pcLoad", int'(last), int'(strobes.pcLoad));
					checkValue("fetch irWrite", int'(last), int'(ctrl.irWrite));
					checkValue("fetch mdrLoad", int'(last), int'(strobes.mdrLoad));
				end
				DECODE: checkValue("decode aluSrcB", 3, int'(ctrl.aluSrcB));
				ADD, SUB, AND, XOR:
				begin
					checkValue("aluSel", aluCode(cls), int'(ctrl.aluSel));
					checkValue("aluSrcA", 1, int'(ctrl.aluSrcA));
				end
				R_WAIT: checkValue("regDst", 1, int'(ctrl.regDst));
				BEQ, BNE:
				begin
					checkValue("aluSel", 2, int'(ctrl.aluSel));
					checkValue("pcSource", 1, int'(ctrl.pcSource));
					checkValue("pcLoad", int'(zero ^ (path[k] == BNE)), int'(strobes.pcLoad));
				end
				J:
				begin
					checkValue("pcLoad", 1, int'(strobes.pcLoad));
					checkValue("pcSource", 2, int'(ctrl.pcSource));
				end
				LUI: checkValue("memToReg", 2, int'(ctrl.memToReg));
				WRITE_BACK: checkValue("memToReg", 1, int'(ctrl.memToReg));
				SW, LW: checkValue("iorD", 1, int'(ctrl.iorD));
				LW_WAIT:
				begin
					checkValue("iorD", 1, int'(ctrl.iorD));
					checkValue("load mdrLoad", int'(last), int'(strobes.mdrLoad));
				end
				BREAK: checkValue("halted outputs", 0, int'({ctrl, strobes}));
				default:;
			endcase
		end
		finishTest();
	endtask

	initial
	begin
		int cls;
		logic zeroFlag;
		logic [1:0] firstZero;	// aluZero of the first BEQ and BNE
		Clk = 1'b0;
		Reset_signal = 1'b1;
		op = '0;
		funct = '0;
		aluZero = 1'b0;
		rngState = 32'hc99;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		cycles = 0;

		holdReset("reset");
		Reset_signal = 1'b0;
		for (int i = 0; i < numInstr; i++)
		begin
			rngState = xorshift(rngState);
			zeroFlag = rngState[16];
			if (i < 12)
				cls = i;	// every class once
			else if (i < 14)
			begin
				cls = i - 8;	// BEQ and BNE again
				zeroFlag = ~firstZero[i - 12];	// other branch sense
			end
			else if (i == numInstr - 1)
				cls = 12;
			else
				cls = int'(rngState % 32'd12);
			if (i == 4 || i == 5)
				firstZero[i - 4] = zeroFlag;
			runInstr(cls, zeroFlag);
		end
		holdReset("reset after halt");
		Reset_signal = 1'b0;
		runInstr(0, 1'b0);

		assertFails = multiCycleControl_i.strobeChecks.failCount;
		$display("tests %0d, failed %0d, bound assertion failures %0d",
			testsRun, testsFailed, assertFails);
		if (testsFailed == 0 && assertFails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/controlSequencer.sv */
`default_nettype none

`include "mc_params.svh"

module controlSequencer (
	input wire logic Clk,
	input wire logic Reset_signal,
	input mcControlPkg::instrClass_e instrClass,
	output mcControlPkg::ctrlState_e state,
	output logic lastWait					// final cycle of FETCH_WAIT or LW_WAIT
);

	import mcControlPkg::*;

	localparam int waitCntWidth = (`MC_MEM_WAIT > 1) ? $clog2(`MC_MEM_WAIT) : 1;
	localparam logic [waitCntWidth-1:0] waitLoadValue = waitCntWidth'(`MC_MEM_WAIT - 1);

	ctrlState_e nextState;
	logic [waitCntWidth-1:0] waitCnt;	// cycles left in current wait state
	logic inWait;
	logic enterWait;

	assign inWait = (state == FETCH_WAIT) || (state == LW_WAIT);
	assign lastWait = inWait && (waitCnt == '0);

	// reload only when arriving from another state
	assign enterWait = (nextState != state) &&
		((nextState == FETCH_WAIT) || (nextState == LW_WAIT));

	always_comb
	begin
		nextState = state;
		case (state)
			RESET:      nextState = FETCH;
			FETCH:      nextState = FETCH_WAIT;
			FETCH_WAIT: nextState = lastWait ? DECODE : FETCH_WAIT;

			DECODE:
			begin
				case (instrClass)
					CLS_ADD:   nextState = ADD;
					CLS_SUB:   nextState = SUB;
					CLS_AND:   nextState = AND;
					CLS_XOR:   nextState = XOR;
					CLS_BREAK: nextState = BREAK;
					CLS_BEQ:   nextState = BEQ;
					CLS_BNE:   nextState = BNE;
					CLS_J:     nextState = J;
					CLS_LUI:   nextState = LUI;
					CLS_LW:    nextState = LW_ADDR;
					CLS_SW:    nextState = SW_ADDR;
					default:   nextState = NOP;
				endcase
			end

			ADD, SUB, AND, XOR: nextState = R_WAIT;	// result written next cycle

			LW_ADDR: nextState = LW;
			LW:      nextState = LW_WAIT;
			LW_WAIT: nextState = lastWait ? WRITE_BACK : LW_WAIT;
			SW_ADDR: nextState = SW;

			R_WAIT, BEQ, BNE, J, LUI, NOP, SW, WRITE_BACK:
			begin
				nextState = FETCH;
			end

			BREAK: nextState = BREAK;	// halted, only reset leaves

			default: nextState = RESET;
		endcase
	end

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			state <= RESET;
			waitCnt <= '0;
		end
		else
		begin
			state <= nextState;
			if (enterWait)
				waitCnt <= waitLoadValue;
			else if (waitCnt != '0)
				waitCnt <= waitCnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/controlSignalDecoder.sv */
`default_nettype none

module controlSignalDecoder (
	input mcControlPkg::ctrlState_e state,
	input wire logic lastWait,
	input wire logic aluZero,		// from ALU, used by BEQ and BNE
	output mcControlPkg::ctrlWord_t ctrl,
	output mcControlPkg::regStrobes_t strobes
);

	import mcControlPkg::*;

	logic branchTaken;

	// BNE jumps on a nonzero difference, BEQ on zero
	assign branchTaken = (state == BNE) ? ~aluZero : aluZero;

	always_comb
	begin
		ctrl = '0;
		strobes = '0;

		case (state)
			RESET:
			begin
				ctrl.regReset = 1'b1;
				strobes.aReset = 1'b1;
				strobes.bReset = 1'b1;
				strobes.pcReset = 1'b1;
				strobes.mdrReset = 1'b1;
				strobes.aluOutReset = 1'b1;
				strobes.irReset = 1'b1;
			end

			FETCH:
			begin
				ctrl.aluSrcB = 2'b01;	// PC + 4 prepared
			end

			FETCH_WAIT:
			begin
				ctrl.aluSrcB = 2'b01;
				if (lastWait)			// instruction word is valid now
				begin
					ctrl.pcWrite = 1'b1;
					ctrl.irWrite = 1'b1;
					ctrl.aluSel = ALU_ADD;
					strobes.mdrLoad = 1'b1;
				end
			end

			DECODE:
			begin
				ctrl.aluSel = ALU_ADD;	// branch target into ALUOut
				ctrl.aluSrcB = 2'b11;
				strobes.aLoad = 1'b1;
				strobes.bLoad = 1'b1;
				strobes.aluOutLoad = 1'b1;
			end

			ADD, SUB, AND, XOR:
			begin
				ctrl.aluSrcA = 1'b1;	// A op B
				strobes.aluOutLoad = 1'b1;
				case (state)
					SUB:     ctrl.aluSel = ALU_SUB;
					AND:     ctrl.aluSel = ALU_AND;
					XOR:     ctrl.aluSel = ALU_XOR;
					default: ctrl.aluSel = ALU_ADD;
				endcase
			end

			R_WAIT:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 2'b01;	// rd
			end

			BEQ, BNE:
			begin
				ctrl.pcWriteCond = 1'b1;
				ctrl.aluSel = ALU_SUB;	// compare A and B
				ctrl.aluSrcA = 1'b1;
				ctrl.pcSource = 2'b01;
			end

			J:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 2'b10;
			end

			LUI:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 3'b010;	// immediate into upper half of rt
			end

			LW_ADDR, SW_ADDR:
			begin
				ctrl.aluSel = ALU_ADD;	// base + offset
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
				strobes.aluOutLoad = 1'b1;
			end

			SW:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.iorD = 1'b1;
			end

			LW:
			begin
				ctrl.iorD = 1'b1;
			end

			LW_WAIT:
			begin
				ctrl.iorD = 1'b1;
				strobes.mdrLoad = lastWait;	// data word valid on last cycle
			end

			WRITE_BACK:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 3'b001;	// MDR into rt
			end

			default:
			begin
				ctrl = '0;	// NOP and BREAK drive nothing
			end
		endcase

		strobes.pcLoad = ctrl.pcWrite | (ctrl.pcWriteCond & branchTaken);
	end

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`default_nettype none

module instrDecoder (
	input mcControlPkg::opcode_e op,
	input mcControlPkg::funct_e funct,		// only meaningful for FUNCT_OP
	output mcControlPkg::instrClass_e instrClass
);

	import mcControlPkg::*;

	always_comb
	begin
		instrClass = CLS_NOP;	// anything unknown falls back to NOP
		case (op)
			FUNCT_OP:
			begin
				case (funct)
					ADD_FUNCT:   instrClass = CLS_ADD;
					SUB_FUNCT:   instrClass = CLS_SUB;
					AND_FUNCT:   instrClass = CLS_AND;
					XOR_FUNCT:   instrClass = CLS_XOR;
					BREAK_FUNCT: instrClass = CLS_BREAK;
					NOP_FUNCT:   instrClass = CLS_NOP;
					default:     instrClass = CLS_NOP;
				endcase
			end

			BEQ_OP: instrClass = CLS_BEQ;
			BNE_OP: instrClass = CLS_BNE;
			J_OP:   instrClass = CLS_J;
			LUI_OP: instrClass = CLS_LUI;
			LW_OP:  instrClass = CLS_LW;
			SW_OP:  instrClass = CLS_SW;

			default:
			begin
				instrClass = CLS_NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/mcControlPkg.sv */
`default_nettype none

`include "mc_params.svh"

package mcControlPkg;

	typedef enum logic [`MC_OP_WIDTH-1:0] {
		FUNCT_OP = 6'h00,	// R-type, look at funct
		J_OP     = 6'h02,
		BEQ_OP   = 6'h04,
		BNE_OP   = 6'h05,
		LUI_OP   = 6'h0f,
		LW_OP    = 6'h23,
		SW_OP    = 6'h2b
	} opcode_e;

	typedef enum logic [`MC_OP_WIDTH-1:0] {
		NOP_FUNCT   = 6'h00,
		BREAK_FUNCT = 6'h0d,
		ADD_FUNCT   = 6'h20,
		SUB_FUNCT   = 6'h22,
		AND_FUNCT   = 6'h24,
		XOR_FUNCT   = 6'h26
	} funct_e;

	typedef enum logic [3:0] {
		CLS_NOP, CLS_ADD, CLS_SUB, CLS_AND, CLS_XOR, CLS_BREAK,
		CLS_BEQ, CLS_BNE, CLS_J, CLS_LUI, CLS_LW, CLS_SW
	} instrClass_e;

	// numbering is visible on stateOut
	typedef enum logic [4:0] {
		RESET, FETCH, FETCH_WAIT, DECODE, BEQ, BNE, LW, SW, LUI, J, NOP,
		ADD, R_WAIT, AND, SUB, XOR, BREAK, LW_ADDR, SW_ADDR, LW_WAIT, WRITE_BACK
	} ctrlState_e;

	typedef enum logic [`MC_ALU_SEL_WIDTH-1:0] {
		ALU_NONE = 3'b000,
		ALU_ADD  = 3'b001,
		ALU_SUB  = 3'b010,
		ALU_AND  = 3'b011,
		ALU_XOR  = 3'b110
	} aluSel_e;

	typedef struct packed {
		logic pcWriteCond;		// branch, PC write depends on zero flag
		logic pcWrite;
		logic memWrite;
		logic irWrite;
		logic regWrite;
		logic regReset;
		aluSel_e aluSel;
		logic [2:0] memToReg;	// 001 MDR, 010 upper immediate
		logic [1:0] pcSource;	// 01 branch target, 10 jump target
		logic aluSrcA;			// 1 selects register A
		logic [1:0] aluSrcB;	// 01 constant 4, 10 offset, 11 offset << 2
		logic iorD;				// 1 selects data address
		logic [1:0] regDst;		// 01 rd field
	} ctrlWord_t;

	typedef struct packed {
		logic aLoad;
		logic aReset;
		logic bLoad;
		logic bReset;
		logic pcLoad;
		logic pcReset;
		logic mdrLoad;
		logic mdrReset;
		logic aluOutLoad;
		logic aluOutReset;
		logic irReset;
	} regStrobes_t;

endpackage

`default_nettype wire

/* src/mc_params.svh */
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// opcode and funct fields of the instruction word
`define MC_OP_WIDTH 6

// state number as seen by the datapath, zero-extended
`define MC_STATE_OUT_WIDTH 8

// ALU operation select
`define MC_ALU_SEL_WIDTH 3

// memory latency in cycles
// FETCH_WAIT and LW_WAIT each last this many cycles
// any value of 1 or more is valid
`define MC_MEM_WAIT 2

`endif

/* src/multiCycleControl.sv */
`default_nettype none

`include "mc_params.svh"

module multiCycleControl (
	input wire logic Clk,
	input wire logic Reset_signal,
	input wire logic [`MC_OP_WIDTH-1:0] op,
	input wire logic [`MC_OP_WIDTH-1:0] funct,
	input wire logic aluZero,
	output logic [`MC_STATE_OUT_WIDTH-1:0] stateOut,
	output mcControlPkg::ctrlWord_t ctrl,
	output mcControlPkg::regStrobes_t strobes
);

	import mcControlPkg::*;

	instrClass_e instrClass;
	ctrlState_e state;
	logic lastWait;

	// raw instruction fields into the decoder enums
	instrDecoder instrDecoder_i (
		.op(opcode_e'(op)),
		.funct(funct_e'(funct)),
		.instrClass(instrClass)
	);

	controlSequencer controlSequencer_i (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.state(state),
		.lastWait(lastWait)
	);

	controlSignalDecoder controlSignalDecoder_i (
		.state(state),
		.lastWait(lastWait),
		.aluZero(aluZero),
		.ctrl(ctrl),
		.strobes(strobes)
	);

	assign stateOut = {{(`MC_STATE_OUT_WIDTH - $bits(ctrlState_e)){1'b0}}, state};

endmodule

`default_nettype wire
